/* Bender.yml */
package:
  name: path_oram

sources:
  - logic/oramPkg.sv
  - logic/oramStash.sv
  - logic/oramFrontEnd.sv
  - logic/oramBackEnd.sv
  - logic/dramScrambler.sv
  - logic/pathOramTop.sv
  - target: test
    files:
      - verif/pathOramChecker.sv
      - verif/pathOramTb.sv

/* list.f */
logic/oramPkg.sv
logic/oramStash.sv
logic/oramFrontEnd.sv
logic/oramBackEnd.sv
logic/dramScrambler.sv
logic/pathOramTop.sv
verif/pathOramChecker.sv
verif/pathOramTb.sv

/* logic/dramScrambler.sv */
`timescale 1ns/1ps

/*
 * DRAM scrambler: XORs block data with an address-keyed pad on
 * writes and strips it from returning read data
 */
module dramScrambler import oramPkg::*; (
	input  logic     Clock,
	input  logic     rst,
	input  dramReq_t Req,
	input  logic     ReqValid,
	output logic     ReqReady,
	output block_t   RdData,
	output logic     RdValid,
	output dramReq_t DramReq,
	output logic     DramReqValid,
	input  logic     DramReqReady,
	input  block_t   DramRdData,
	input  logic     DramRdValid
);

	typedef logic [$clog2(TreeLevels*SlotsPerBucket)-1:0] ptr_t;

	// One full path of reads can be outstanding
	logic [DramAddrWidth-1:0] rdAddrFifo [TreeLevels*SlotsPerBucket];
	ptr_t wrPtr;
	ptr_t rdPtr;
	logic [$clog2(TreeLevels*SlotsPerBucket):0] count;
	logic full;
	logic push;

	// Key XOR the word address repeated across the data width
	function automatic logic [DataWidth-1:0] pad(input logic [DramAddrWidth-1:0] a);
		return DramKey ^ DataWidth'({((DataWidth + DramAddrWidth - 1) / DramAddrWidth){a}});
	endfunction

	// ------------------------------------------------------------
	// Request path, combinational
	// ------------------------------------------------------------
	always_comb begin
		DramReq = Req;
		if (Req.op == DramWrite) DramReq.wdata.data = Req.wdata.data ^ pad(Req.dramAddr);
	end

	assign full = count == (TreeLevels * SlotsPerBucket);
	assign DramReqValid = ReqValid && !full;
	assign ReqReady = DramReqReady && !full;
	assign push = DramReqValid && DramReqReady && Req.op == DramRead;

	// ------------------------------------------------------------
	// Read address FIFO and read return
	// ------------------------------------------------------------
	always_ff @(posedge Clock) begin
		if (rst) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			RdValid <= 1'b0;
		end else begin
			RdValid <= DramRdValid;
			if (push) wrPtr <= wrPtr + 1'b1;
			if (DramRdValid) rdPtr <= rdPtr + 1'b1;
			case ({push, DramRdValid})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge Clock) begin
		if (push) rdAddrFifo[wrPtr] <= Req.dramAddr;
		if (DramRdValid) begin
			RdData.valid <= DramRdData.valid;
			RdData.addr <= DramRdData.addr;
			RdData.leaf <= DramRdData.leaf;
			RdData.data <= DramRdData.data ^ pad(rdAddrFifo[rdPtr]);
		end
	end

endmodule

/* logic/oramBackEnd.sv */
`timescale 1ns/1ps

/*
 * Path ORAM back end: reads one tree path into the stash, serves
 * the block, then writes the path back leaf first
 */
module oramBackEnd import oramPkg::*; (
	input  logic                 Clock,
	input  logic                 rst,
	input  beCmd_t               BeCmd,
	input  logic                 BeCmdValid,
	output logic                 BeCmdReady,
	output logic [DataWidth-1:0] Resp,
	output logic                 RespValid,
	input  logic                 RespReady,
	output dramReq_t             Req,
	output logic                 ReqValid,
	input  logic                 ReqReady,
	input  block_t               RdData,
	input  logic                 RdValid
);

	typedef enum logic [2:0] {Idle, ReadPath, Serve, WritePath, Reply} beState_e;
	typedef logic [$clog2(TreeLevels)-1:0] level_t;

	beState_e state;
	beCmd_t cmd;
	logic [$clog2(TreeLevels*SlotsPerBucket)-1:0] reqCnt;
	logic [$clog2(TreeLevels*SlotsPerBucket)-1:0] rspCnt;
	logic reqsDone;
	logic reqFire;
	level_t level;
	logic insert;
	logic update;
	logic evict;
	logic hit;
	logic evictValid;
	block_t insertBlock;
	block_t servedBlock;
	block_t evictBlock;
	logic [DataWidth-1:0] hitData;
	logic [DataWidth-1:0] oldData;

	// Heap order, so level k starts at bucket 2^k - 1
	function automatic logic [DramAddrWidth-1:0] slotAddr(
		input logic [LeafWidth-1:0] leaf,
		input level_t lvl,
		input logic slot
	);
		logic [DramAddrWidth-2:0] bucket;
		bucket = ((DramAddrWidth-1)'(1) << lvl) - (DramAddrWidth-1)'(1)
			+ (DramAddrWidth-1)'(leaf >> (LeafWidth - lvl));
		return {bucket, slot};
	endfunction

	// ------------------------------------------------------------
	// DRAM requests
	// ------------------------------------------------------------
	// Root to leaf on reads, leaf to root on writes
	assign level = (state == WritePath) ? level_t'(TreeLevels - 1) - reqCnt[2:1] : reqCnt[2:1];

	always_comb begin
		Req.op = (state == WritePath) ? DramWrite : DramRead;
		Req.dramAddr = slotAddr(cmd.oldLeaf, level, reqCnt[0]);
		Req.wdata = '0;
		if (state == WritePath && evictValid) Req.wdata = evictBlock;
	end

	assign ReqValid = (state == ReadPath && !reqsDone) || state == WritePath;
	assign reqFire = ReqValid && ReqReady;

	// ------------------------------------------------------------
	// Stash control
	// ------------------------------------------------------------
	assign oldData = hit ? hitData : '0;

	always_comb begin
		servedBlock.valid = 1'b1;
		servedBlock.addr = cmd.addr;
		servedBlock.leaf = cmd.newLeaf;
		servedBlock.data = (cmd.op == OpWrite) ? cmd.data : oldData;
	end

	assign insert = (state == ReadPath && RdValid && RdData.valid) || (state == Serve && !hit);
	assign update = (state == Serve) && hit;
	assign insertBlock = (state == Serve) ? servedBlock : RdData;
	assign evict = (state == WritePath) && reqFire && evictValid;

	oramStash u_stash (
		.Clock(Clock),
		.rst(rst),
		.Insert(insert),
		.InsertBlock(insertBlock),
		.LookupAddr(cmd.addr),
		.Hit(hit),
		.HitData(hitData),
		.Update(update),
		.UpdateData(servedBlock),
		.EvictLevel(level),
		.EvictLeaf(cmd.oldLeaf),
		.EvictValid(evictValid),
		.EvictBlock(evictBlock),
		.Evict(evict)
	);

	// ------------------------------------------------------------
	// Path FSM, counters wrap back to zero after each pass
	// ------------------------------------------------------------
	always_ff @(posedge Clock) begin
		if (rst) begin
			state <= Idle;
			reqCnt <= '0;
			rspCnt <= '0;
			reqsDone <= 1'b0;
		end else begin
			if (reqFire) reqCnt <= reqCnt + 1'b1;
			case (state)
				Idle: if (BeCmdValid) begin
					state <= ReadPath;
					reqsDone <= 1'b0;
				end
				ReadPath: begin
					if (reqFire && &reqCnt) reqsDone <= 1'b1;
					if (RdValid) begin
						rspCnt <= rspCnt + 1'b1;
						if (&rspCnt) state <= Serve;
					end
				end
				Serve: state <= WritePath;
				WritePath: if (reqFire && &reqCnt) state <= Reply;
				Reply: if (RespReady) state <= Idle;
				default: state <= Idle;
			endcase
		end
	end

	always_ff @(posedge Clock) begin
		if (state == Idle && BeCmdValid) cmd <= BeCmd;
		if (state == Serve) Resp <= oldData;
	end

	assign BeCmdReady = state == Idle;
	assign RespValid = state == Reply;

endmodule

/* logic/oramFrontEnd.sv */
`timescale 1ns/1ps

/*
 * Path ORAM front end: position map lookup, random leaf remap and
 * sequencing of network commands into back-end accesses
 */
module oramFrontEnd import oramPkg::*; (
	input  logic                 Clock,
	input  logic                 rst,
	input  oramCmd_t             Cmd,
	input  logic                 CmdValid,
	output logic                 CmdReady,
	output logic [DataWidth-1:0] DataOut,
	output logic                 DataOutValid,
	input  logic                 DataOutReady,
	output beCmd_t               BeCmd,
	output logic                 BeCmdValid,
	input  logic                 BeCmdReady,
	input  logic [DataWidth-1:0] Resp,
	input  logic                 RespValid,
	output logic                 RespReady
);

	typedef enum logic [1:0] {Idle, Issue, Respond} feState_e;

	feState_e state;
	logic [LeafWidth-1:0] posMap [NumAddr];
	logic [15:0] lfsr;
	logic cmdFire;

	assign cmdFire = CmdValid && CmdReady;

	// Free-running Fibonacci LFSR, taps 16 14 13 11
	always_ff @(posedge Clock) begin
		if (rst) begin
			lfsr <= 16'hACE1;
		end else begin
			lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
		end
	end

	// ------------------------------------------------------------
	// Position map, remapped on every accepted command
	// ------------------------------------------------------------
	always_ff @(posedge Clock) begin
		if (rst) begin
			for (int i = 0; i < NumAddr; i++) begin
				posMap[i] <= LeafWidth'(i % NumLeaves);
			end
		end else if (cmdFire) begin
			posMap[Cmd.addr] <= lfsr[LeafWidth-1:0];
		end
	end

	// Old leaf comes from the map before the write lands
	always_ff @(posedge Clock) begin
		if (cmdFire) begin
			BeCmd.op <= Cmd.op;
			BeCmd.addr <= Cmd.addr;
			BeCmd.oldLeaf <= posMap[Cmd.addr];
			BeCmd.newLeaf <= lfsr[LeafWidth-1:0];
			BeCmd.data <= Cmd.data;
		end
	end

	// ------------------------------------------------------------
	// Sequencing
	// ------------------------------------------------------------
	always_ff @(posedge Clock) begin
		if (rst) begin
			state <= Idle;
		end else begin
			case (state)
				Idle: if (cmdFire) state <= Issue;
				Issue: if (BeCmdReady) state <= Respond;
				Respond: if (RespValid && DataOutReady) state <= Idle;
				default: state <= Idle;
			endcase
		end
	end

	assign CmdReady = state == Idle;
	assign BeCmdValid = state == Issue;
	// Response flows straight out, back pressure goes straight back
	assign DataOut = Resp;
	assign DataOutValid = (state == Respond) && RespValid;
	assign RespReady = (state == Respond) && DataOutReady;

endmodule

/* logic/oramPkg.sv */
/*
 * Path ORAM shared definitions: tree geometry, opcodes and the
 * command, block and DRAM request formats
 */
package oramPkg;

	// ------------------------------------------------------------
	// Geometry
	// ------------------------------------------------------------
	localparam int NumAddr = 16;
	localparam int AddrWidth = 4;
	localparam int TreeLevels = 4;
	localparam int LeafWidth = 3;
	localparam int NumLeaves = 8;
	localparam int SlotsPerBucket = 2;
	localparam int NumBuckets = 15;
	// One DRAM word per slot, heap-ordered buckets
	localparam int DramAddrWidth = $clog2(NumBuckets * SlotsPerBucket);
	localparam int DataWidth = 32;
	localparam int StashSize = 16;
	localparam logic [DataWidth-1:0] DramKey = 32'h5A3C_96E1;

	// ------------------------------------------------------------
	// Opcodes and transfer formats
	// ------------------------------------------------------------
	typedef enum logic {OpRead, OpWrite} oramOp_e;
	typedef enum logic {DramRead, DramWrite} dramOp_e;

	typedef struct packed {
		oramOp_e op;
		logic [AddrWidth-1:0] addr;
		logic [DataWidth-1:0] data;
	} oramCmd_t;

	typedef struct packed {
		oramOp_e op;
		logic [AddrWidth-1:0] addr;
		logic [LeafWidth-1:0] oldLeaf;
		logic [LeafWidth-1:0] newLeaf;
		logic [DataWidth-1:0] data;
	} beCmd_t;

	// 40 bits, one DRAM word or one stash entry
	typedef struct packed {
		logic valid;
		logic [AddrWidth-1:0] addr;
		logic [LeafWidth-1:0] leaf;
		logic [DataWidth-1:0] data;
	} block_t;

	typedef struct packed {
		dramOp_e op;
		logic [DramAddrWidth-1:0] dramAddr;
		block_t wdata;
	} dramReq_t;

endpackage

/* logic/oramStash.sv */
`timescale 1ns/1ps

/*
 * Path ORAM stash: block storage with insert, address lookup with
 * in-place update, and deepest-fit eviction search
 */
module oramStash import oramPkg::*; (
	input  logic                          Clock,
	input  logic                          rst,
	input  logic                          Insert,
	input  block_t                        InsertBlock,
	input  logic [AddrWidth-1:0]          LookupAddr,
	output logic                          Hit,
	output logic [DataWidth-1:0]          HitData,
	input  logic                          Update,
	input  block_t                        UpdateData,
	input  logic [$clog2(TreeLevels)-1:0] EvictLevel,
	input  logic [LeafWidth-1:0]          EvictLeaf,
	output logic                          EvictValid,
	output block_t                        EvictBlock,
	input  logic                          Evict
);

	typedef logic [$clog2(StashSize)-1:0] idx_t;

	block_t entries [StashSize];
	logic [StashSize-1:0] entryValid;
	idx_t freeIdx;
	idx_t hitIdx;
	idx_t evictIdx;

	// ------------------------------------------------------------
	// Search, lowest index wins
	// ------------------------------------------------------------
	always_comb begin
		freeIdx = '0;
		hitIdx = '0;
		evictIdx = '0;
		Hit = 1'b0;
		EvictValid = 1'b0;
		for (int i = StashSize - 1; i >= 0; i--) begin
			if (!entryValid[i]) freeIdx = idx_t'(i);
			if (entryValid[i] && entries[i].addr == LookupAddr) begin
				Hit = 1'b1;
				hitIdx = idx_t'(i);
			end
			// Leaves share a path down to EvictLevel if their top bits agree
			if (entryValid[i] &&
					((entries[i].leaf ^ EvictLeaf) >> (LeafWidth - EvictLevel)) == '0) begin
				EvictValid = 1'b1;
				evictIdx = idx_t'(i);
			end
		end
	end

	assign HitData = entries[hitIdx].data;
	assign EvictBlock = entries[evictIdx];

	always_ff @(posedge Clock) begin
		if (rst) begin
			entryValid <= '0;
		end else begin
			if (Insert) entryValid[freeIdx] <= 1'b1;
			if (Evict) entryValid[evictIdx] <= 1'b0;
		end
	end

	always_ff @(posedge Clock) begin
		if (Insert) entries[freeIdx] <= InsertBlock;
		if (Update) entries[hitIdx] <= UpdateData;
	end

endmodule

/* logic/pathOramTop.sv */
`timescale 1ns/1ps

/*
 * Path ORAM top: front end, back end and DRAM scrambler
 */
module pathOramTop import oramPkg::*; (
	input  logic                 Clock,
	input  logic                 rst,
	input  oramCmd_t             Cmd,
	input  logic                 CmdValid,
	output logic                 CmdReady,
	output logic [DataWidth-1:0] DataOut,
	output logic                 DataOutValid,
	input  logic                 DataOutReady,
	output dramReq_t             DramReq,
	output logic                 DramReqValid,
	input  logic                 DramReqReady,
	input  block_t               DramRdData,
	input  logic                 DramRdValid
);

	// ------------------------------------------------------------
	// Internal channels
	// ------------------------------------------------------------
	beCmd_t beCmd;
	logic beCmdValid;
	logic beCmdReady;
	logic [DataWidth-1:0] resp;
	logic respValid;
	logic respReady;
	dramReq_t req;
	logic reqValid;
	logic reqReady;
	block_t rdData;
	logic rdValid;

	oramFrontEnd u_frontEnd (
		.Clock(Clock),
		.rst(rst),
		.Cmd(Cmd),
		.CmdValid(CmdValid),
		.CmdReady(CmdReady),
		.DataOut(DataOut),
		.DataOutValid(DataOutValid),
		.DataOutReady(DataOutReady),
		.BeCmd(beCmd),
		.BeCmdValid(beCmdValid),
		.BeCmdReady(beCmdReady),
		.Resp(resp),
		.RespValid(respValid),
		.RespReady(respReady)
	);

	oramBackEnd u_backEnd (
		.Clock(Clock),
		.rst(rst),
		.BeCmd(beCmd),
		.BeCmdValid(beCmdValid),
		.BeCmdReady(beCmdReady),
		.Resp(resp),
		.RespValid(respValid),
		.RespReady(respReady),
		.Req(req),
		.ReqValid(reqValid),
		.ReqReady(reqReady),
		.RdData(rdData),
		.RdValid(rdValid)
	);

	// Sits where block encryption would go
	dramScrambler u_scrambler (
		.Clock(Clock),
		.rst(rst),
		.Req(req),
		.ReqValid(reqValid),
		.ReqReady(reqReady),
		.RdData(rdData),
		.RdValid(rdValid),
		.DramReq(DramReq),
		.DramReqValid(DramReqValid),
		.DramReqReady(DramReqReady),
		.DramRdData(DramRdData),
		.DramRdValid(DramRdValid)
	);

endmodule

/* verif/pathOramChecker.sv */
`timescale 1ns/1ps

/*
 * Path ORAM checker with a reference memory for DataOut, and path order,
 * remapping, scrambling and handshake checks on the DUT ports
 */
module pathOramChecker import oramPkg::*; (
	input  logic                 Clock,
	input  logic                 rst,
	input  oramCmd_t             Cmd,
	input  logic                 CmdValid,
	input  logic                 CmdReady,
	input  logic [DataWidth-1:0] DataOut,
	input  logic                 DataOutValid,
	input  logic                 DataOutReady,
	input  dramReq_t             DramReq,
	input  logic                 DramReqValid,
	input  logic                 DramReqReady,
	output int                   RespCount,
	output int                   DataErrors,
	output int                   PathErrors,
	output int                   LeafErrors,
	output int                   ScrambleErrors,
	output int                   HandshakeErrors
);

	localparam int PathWords = TreeLevels * SlotsPerBucket;

	logic [DataWidth-1:0] refMem [NumAddr];
	logic [DataWidth-1:0] expQueue [$];
	logic [DramAddrWidth-1:0] rdAddrs [$];
	logic [DramAddrWidth-1:0] wrAddrs [$];
	// Last leaf seen in a DRAM write for each address
	int knownLeaf [NumAddr];
	logic leafKnown [NumAddr];
	logic accessed [NumAddr];
	logic leafCheck;
	int leafExpected;
	logic busy;

	// ------------------------------------------------------------
	// Reference model
	// ------------------------------------------------------------
	// Returns the old value for both ops and then applies the write
	function logic [DataWidth-1:0] refAccess(input oramCmd_t c);
		logic [DataWidth-1:0] old;
		old = refMem[c.addr];
		if (c.op == OpWrite) refMem[c.addr] = c.data;
		return old;
	endfunction

	// Key XOR the word address repeated from bit 0 upward
	function automatic logic [DataWidth-1:0] padFor(input logic [DramAddrWidth-1:0] a);
		logic [DataWidth-1:0] rep;
		for (int i = 0; i < DataWidth; i++) rep[i] = a[i % DramAddrWidth];
		return rep ^ DramKey;
	endfunction

	// Walk down from the root through children 2b+1 and 2b+2
	function automatic int pathAddr(input int leaf, input int lvl, input int slot);
		int bucket;
		bucket = 0;
		for (int l = 1; l <= lvl; l++) begin
			bucket = 2 * bucket + 1 + ((leaf >> (LeafWidth - l)) & 1);
		end
		return bucket * SlotsPerBucket + slot;
	endfunction

	// ------------------------------------------------------------
	// Per-access bookkeeping
	// ------------------------------------------------------------
	task automatic startAccess(input oramCmd_t c);
		expQueue.push_back(refAccess(c));
		if (!accessed[c.addr]) begin
			leafCheck = 1'b1;
			leafExpected = int'(c.addr) % NumLeaves;
		end else begin
			leafCheck = leafKnown[c.addr];
			leafExpected = knownLeaf[c.addr];
		end
		accessed[c.addr] = 1'b1;
		leafKnown[c.addr] = 1'b0;
		rdAddrs.delete();
		wrAddrs.delete();
	endtask

	task automatic watchDram(input dramReq_t r);
		logic [DataWidth-1:0] plain;
		if (r.op == DramRead) begin
			if (wrAddrs.size() > 0) begin
				PathErrors++;
				$display("[FAIL] %0t: DRAM read of %0d after path writes began", $time, r.dramAddr);
			end
			rdAddrs.push_back(r.dramAddr);
		end else begin
			wrAddrs.push_back(r.dramAddr);
			plain = r.wdata.data ^ padFor(r.dramAddr);
			if (r.wdata.valid) begin
				knownLeaf[r.wdata.addr] = int'(r.wdata.leaf);
				leafKnown[r.wdata.addr] = 1'b1;
				if (plain !== refMem[r.wdata.addr]) begin
					ScrambleErrors++;
					$display("[FAIL] %0t: word %0d of address %0d unscrambles to %h, expected %h",
						$time, r.dramAddr, r.wdata.addr, plain, refMem[r.wdata.addr]);
				end
			end else if (plain !== '0) begin
				ScrambleErrors++;
				$display("[FAIL] %0t: empty DRAM word %0d unscrambles to %h",
					$time, r.dramAddr, plain);
			end
		end
	endtask

	task automatic checkPath();
		int leaf;
		int want;
		logic found;
		logic dup;
		if (rdAddrs.size() != PathWords || wrAddrs.size() != PathWords) begin
			PathErrors++;
			$display("[FAIL] %0t: access made %0d DRAM reads and %0d writes, expected %0d each",
				$time, rdAddrs.size(), wrAddrs.size(), PathWords);
		end else begin
			leaf = int'(rdAddrs[PathWords-1]) / SlotsPerBucket - (NumLeaves - 1);
			if (leaf < 0 || leaf >= NumLeaves) leaf = 0;
			for (int i = 0; i < PathWords; i++) begin
				want = pathAddr(leaf, i / SlotsPerBucket, i % SlotsPerBucket);
				if (int'(rdAddrs[i]) != want) begin
					PathErrors++;
					$display("[FAIL] %0t: read %0d went to word %0d, path to leaf %0d expects %0d",
						$time, i, rdAddrs[i], leaf, want);
				end
			end
			for (int i = 0; i < PathWords; i++) begin
				found = 1'b0;
				dup = 1'b0;
				for (int j = 0; j < PathWords; j++) begin
					if (rdAddrs[j] == wrAddrs[i]) found = 1'b1;
				end
				for (int j = 0; j < i; j++) begin
					if (wrAddrs[j] == wrAddrs[i]) dup = 1'b1;
				end
				if (!found || dup) begin
					PathErrors++;
					$display("[FAIL] %0t: write to word %0d does not match the read path",
						$time, wrAddrs[i]);
				end
			end
			if (leafCheck && leaf != leafExpected) begin
				LeafErrors++;
				$display("[FAIL] %0t: path read for leaf %0d, position map should give %0d",
					$time, leaf, leafExpected);
			end
		end
	endtask

	task automatic finishAccess(input logic [DataWidth-1:0] d);
		logic [DataWidth-1:0] exp;
		RespCount++;
		if (expQueue.size() == 0) begin
			DataErrors++;
			$display("[FAIL] %0t: DataOut %h with no command outstanding", $time, d);
		end else begin
			exp = expQueue.pop_front();
			if (d !== exp) begin
				DataErrors++;
				$display("[FAIL] %0t: DataOut %h, expected %h", $time, d, exp);
			end
		end
		checkPath();
	endtask

	// ------------------------------------------------------------
	// Monitor sampled on the rising edge
	// ------------------------------------------------------------
	initial begin
		RespCount = 0;
		DataErrors = 0;
		PathErrors = 0;
		LeafErrors = 0;
		ScrambleErrors = 0;
		HandshakeErrors = 0;
		leafCheck = 1'b0;
		leafExpected = 0;
		busy = 1'b0;
		for (int i = 0; i < NumAddr; i++) begin
			refMem[i] = '0;
			knownLeaf[i] = 0;
			leafKnown[i] = 1'b0;
			accessed[i] = 1'b0;
		end
		forever begin
			@(posedge Clock);
			if (!rst) begin
				// One access at a time, so no new command until DataOut is taken
				if (busy && CmdReady) begin
					HandshakeErrors++;
					$display("[FAIL] %0t: CmdReady high while an access is in flight", $time);
				end
				if (CmdValid && CmdReady) begin
					startAccess(Cmd);
					busy = 1'b1;
				end
				if (DramReqValid && DramReqReady) watchDram(DramReq);
				if (DataOutValid && DataOutReady) begin
					finishAccess(DataOut);
					busy = 1'b0;
				end
			end
		end
	end

endmodule

/* verif/pathOramTb.sv */
`timescale 1ns/1ps

/*
 * Path ORAM testbench with clock, reset, a DRAM model with random
 * latency and back pressure, command stimulus and timeout
 */
module pathOramTb import oramPkg::*; ();

	localparam int NumRandom = 300;
	localparam int NumCmds = NumAddr + NumRandom;
	localparam int CycleLimit = NumCmds * 200;
	localparam int DramWords = NumBuckets * SlotsPerBucket;

	logic Clock;
	logic rst;
	oramCmd_t Cmd;
	logic CmdValid;
	logic CmdReady;
	logic [DataWidth-1:0] DataOut;
	logic DataOutValid;
	logic DataOutReady;
	dramReq_t DramReq;
	logic DramReqValid;
	logic DramReqReady;
	block_t DramRdData;
	logic DramRdValid;

	integer seed;
	int cycles;
	int respCount;
	int dataErrors;
	int pathErrors;
	int leafErrors;
	int scrambleErrors;
	int handshakeErrors;
	oramCmd_t cmdList [NumCmds];
	block_t dramMem [DramWords];
	block_t rdQueue [$];
	int rdDue [$];

	pathOramTop u_pathOramTop (
		.Clock(Clock),
		.rst(rst),
		.Cmd(Cmd),
		.CmdValid(CmdValid),
		.CmdReady(CmdReady),
		.DataOut(DataOut),
		.DataOutValid(DataOutValid),
		.DataOutReady(DataOutReady),
		.DramReq(DramReq),
		.DramReqValid(DramReqValid),
		.DramReqReady(DramReqReady),
		.DramRdData(DramRdData),
		.DramRdValid(DramRdValid)
	);

	pathOramChecker u_checker (
		.Clock(Clock),
		.rst(rst),
		.Cmd(Cmd),
		.CmdValid(CmdValid),
		.CmdReady(CmdReady),
		.DataOut(DataOut),
		.DataOutValid(DataOutValid),
		.DataOutReady(DataOutReady),
		.DramReq(DramReq),
		.DramReqValid(DramReqValid),
		.DramReqReady(DramReqReady),
		.RespCount(respCount),
		.DataErrors(dataErrors),
		.PathErrors(pathErrors),
		.LeafErrors(leafErrors),
		.ScrambleErrors(scrambleErrors),
		.HandshakeErrors(handshakeErrors)
	);

	initial begin
		Clock = 1'b0;
		forever #5 Clock = ~Clock;
	end

	task automatic sendCmd(input oramCmd_t c);
		Cmd = c;
		CmdValid = 1'b1;
		@(posedge Clock);
		while (!CmdReady) @(posedge Clock);
		#1 CmdValid = 1'b0;
	endtask

	task automatic printCounts();
		$display("Errors: data %0d path %0d remap %0d scramble %0d handshake %0d, %0d of %0d",
			dataErrors, pathErrors, leafErrors, scrambleErrors, handshakeErrors,
			respCount, NumCmds);
	endtask

	// ------------------------------------------------------------
	// DRAM model with in-order reads and 1 to 4 cycles of latency
	// ------------------------------------------------------------
	initial begin
		int now;
		DramReqReady = 1'b0;
		DramRdValid = 1'b0;
		DramRdData = '0;
		DataOutReady = 1'b0;
		now = 0;
		for (int i = 0; i < DramWords; i++) dramMem[i] = '0;
		forever begin
			@(posedge Clock);
			now++;
			if (!rst && DramReqValid && DramReqReady) begin
				if (DramReq.op == DramWrite) begin
					dramMem[DramReq.dramAddr] = DramReq.wdata;
				end else begin
					rdQueue.push_back(dramMem[DramReq.dramAddr]);
					rdDue.push_back(now + 1 + int'($unsigned($random(seed)) % 4));
				end
			end
			#1;
			DramRdValid = 1'b0;
			if (rdQueue.size() > 0 && rdDue[0] <= now) begin
				DramRdData = rdQueue.pop_front();
				void'(rdDue.pop_front());
				DramRdValid = 1'b1;
			end
			// Ready low about a fifth of the time
			DramReqReady = ($unsigned($random(seed)) % 10) >= 2;
			DataOutReady = ($unsigned($random(seed)) % 4) != 0;
		end
	end

	// ------------------------------------------------------------
	// Stimulus
	// ------------------------------------------------------------
	initial begin
		logic [31:0] r;
		rst = 1'b1;
		CmdValid = 1'b0;
		Cmd = '0;
		seed = 18355;
		// Every address read once before any write
		for (int i = 0; i < NumAddr; i++) begin
			cmdList[i].op = OpRead;
			cmdList[i].addr = AddrWidth'(i);
			cmdList[i].data = '0;
		end
		for (int i = NumAddr; i < NumCmds; i++) begin
			r = $random(seed);
			cmdList[i].op = r[8] ? OpWrite : OpRead;
			cmdList[i].addr = r[AddrWidth-1:0];
			cmdList[i].data = $random(seed);
		end
		repeat (10) @(posedge Clock);
		#1 rst = 1'b0;
		for (int i = 0; i < NumCmds; i++) sendCmd(cmdList[i]);
		while (respCount < NumCmds) @(posedge Clock);
		repeat (2) @(posedge Clock);
		printCounts();
		if (dataErrors + pathErrors + leafErrors + scrambleErrors + handshakeErrors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

	// Watchdog
	initial begin
		cycles = 0;
		while (cycles < CycleLimit) begin
			@(posedge Clock);
			cycles++;
		end
		$display("Timeout: the run did not finish within %0d cycles", CycleLimit);
		printCounts();
		$display("Checks failed");
		$finish;
	end

endmodule
